/* files.f */
+incdir+include
rtl/board_pkg.sv
rtl/board_cfg_if.sv
rtl/dip_decode.sv
rtl/joy_4way_filter.sv
rtl/input_mapper.sv
rtl/board_control.sv
rtl/game_reset_gen.sv
rtl/board_top.sv
dv/tb_board.sv

/* run_sim.sh */
#!/bin/sh
# build and run the board testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_board \
    -f files.f --Mdir obj_dir -o tb_board_sim

./obj_dir/tb_board_sim > sim.log 2>&1
cat sim.log

if grep -q "sim failed" sim.log; then
    exit 1
fi
exit 0

/* dv/tb_board.sv */
// board wrapper testbench

`timescale 1ns/1ps

`include "board_defs.svh"

module tb_board;

    localparam int CLK_PERIOD      = 4;
    localparam int WATCHDOG_CYCLES = 2000;
    localparam int RST_LEN         = `BOARD_GAME_RST_LEN;

    logic                 clk_sys, rst, rst_req, downloading;
    logic [ 6:0]          core_mod;
    logic [31:0]          status;
    board_pkg::raw_joy_t  board_joystick1, board_joystick2, board_joystick3, board_joystick4;
    board_pkg::game_joy_t key_joy1, key_joy2, key_joy3;
    logic [ 3:0]          key_start, key_coin, key_gfx;
    logic                 key_service, key_reset, key_pause;
    logic                 game_rst, game_rst_n, game_service, dip_test, dip_pause;
    board_pkg::game_joy_t game_joystick1, game_joystick2, game_joystick3, game_joystick4;
    logic [ 3:0]          game_coin, game_start, gfx_en;
    logic [ 1:0]          dip_fxlevel;

    board_pkg::raw_joy_t  raw_v [4];
    board_pkg::game_joy_t key_v [4];    // player 4 entry stays zero
    int seed   = 48039;
    int errors = 0;
    int checks = 0;

    board_top dut (.*);

    always #(CLK_PERIOD / 2) clk_sys = ~clk_sys;

    // inputs change 1 ns after the edge, outputs are read there too
    task automatic tick(input int n);
        repeat (n) begin
            @(posedge clk_sys);
            #1;
        end
    endtask

    task automatic check_joy(input string what, input board_pkg::game_joy_t got,
                             input board_pkg::game_joy_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_nib(input string what, input logic [3:0] got, input logic [3:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_fx(input string what, input logic [1:0] got, input logic [1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_bit(input string what, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_count(input string what, input int got, input int exp);
        checks++;
        if (got != exp) begin
            errors++;
            $display("FAILED at %0t: %s took %0d cycles, expected %0d", $time, what, got, exp);
        end
    endtask

    // active-low game view of a merged joystick
    function automatic board_pkg::game_joy_t expect_joy(input board_pkg::raw_joy_t raw,
                                                        input board_pkg::game_joy_t key,
                                                        input logic rot);
        board_pkg::game_joy_t m;
        board_pkg::dir_t      d;
        m = raw[`BOARD_JOY_W-1:0] | key;
        d = m[3:0];
        if (rot) begin
            m[0] = d[1];
            m[1] = d[0];
            m[2] = d[3];
            m[3] = d[2];
        end
        return ~m;
    endfunction

    task automatic drive_joys();
        board_joystick1 = raw_v[0];
        board_joystick2 = raw_v[1];
        board_joystick3 = raw_v[2];
        board_joystick4 = raw_v[3];
        key_joy1 = key_v[0];
        key_joy2 = key_v[1];
        key_joy3 = key_v[2];
    endtask

    task automatic randomize_joys();
        for (int p = 0; p < 4; p++) begin
            raw_v[p] = board_pkg::raw_joy_t'($random(seed));
            raw_v[p][`BOARD_PAUSE_BIT] = 1'b0;  // keep pause state untouched
            key_v[p] = (p < 3) ? board_pkg::game_joy_t'($random(seed)) : '0;
        end
        drive_joys();
    endtask

    task automatic clear_joys();
        for (int p = 0; p < 4; p++) begin
            raw_v[p] = '0;
            key_v[p] = '0;
        end
        drive_joys();
    endtask

    // counts cycles with game_rst high, from its first high sample
    task automatic rst_pulse_len(output int len);
        int wait_cnt;
        wait_cnt = 0;
        len      = 0;
        while (!game_rst && wait_cnt < 8) begin
            tick(1);
            wait_cnt++;
        end
        while (game_rst && len < 64) begin
            tick(1);
            len++;
        end
        if (wait_cnt >= 8) begin
            errors++;
            $display("game_rst was never asserted at %0t", $time);
        end
    endtask

    task automatic test_reset();
        int cnt;
        cnt = 0;
        rst = 1'b0;
        while (game_rst && cnt < 64) begin
            tick(1);
            cnt++;
        end
        check_count("game_rst release after rst", cnt, RST_LEN + 1);
        check_bit("game_rst_n at release", game_rst_n, 1'b0);
        tick(1);
        check_bit("game_rst_n one cycle later", game_rst_n, 1'b0);
        tick(1);
        check_bit("game_rst_n two cycles later", game_rst_n, 1'b1);
        check_nib("gfx_en after reset", gfx_en, 4'hf);
        check_bit("dip_pause after reset", dip_pause, 1'b1);
    endtask

    // test switch is active low, fx level is a plain copy
    task automatic test_status_fields();
        status[`BOARD_ST_TEST]       = 1'b1;
        status[`BOARD_ST_FX_LO +: 2] = 2'b10;
        tick(4);
        check_bit("dip_test with test bit set", dip_test, 1'b0);
        check_fx("dip_fxlevel", dip_fxlevel, 2'b10);
        status[`BOARD_ST_TEST]       = 1'b0;
        status[`BOARD_ST_FX_LO +: 2] = 2'b01;
        tick(4);
        check_bit("dip_test with test bit clear", dip_test, 1'b1);
        check_fx("dip_fxlevel", dip_fxlevel, 2'b01);
        status[`BOARD_ST_FX_LO +: 2] = 2'b00;
    endtask

    task automatic test_joy_map(input logic rot);
        status[`BOARD_ST_ROT] = rot;
        for (int n = 0; n < 4; n++) begin
            randomize_joys();
            tick(4);
            check_joy("joystick1", game_joystick1, expect_joy(raw_v[0], key_v[0], rot));
            check_joy("joystick2", game_joystick2, expect_joy(raw_v[1], key_v[1], rot));
            check_joy("joystick3", game_joystick3, expect_joy(raw_v[2], key_v[2], rot));
            check_joy("joystick4", game_joystick4, expect_joy(raw_v[3], key_v[3], rot));
        end
        status[`BOARD_ST_ROT] = 1'b0;
    endtask

    task automatic test_coin_start();
        logic [3:0] exp_coin;
        logic [3:0] exp_start;
        for (int n = 0; n < 4; n++) begin
            randomize_joys();
            key_coin    = 4'($random(seed));
            key_start   = 4'($random(seed));
            key_service = 1'($random(seed));
            for (int p = 0; p < 4; p++) begin
                exp_coin[p]  = ~(raw_v[p][`BOARD_COIN_BIT] | key_coin[p]);
                exp_start[p] = ~(raw_v[p][`BOARD_START_BIT] | key_start[p]);
            end
            tick(4);
            check_nib("game_coin", game_coin, exp_coin);
            check_nib("game_start", game_start, exp_start);
            check_bit("game_service", game_service, ~key_service);
        end
        key_coin    = '0;
        key_start   = '0;
        key_service = 1'b0;
    endtask

    task automatic test_4way();
        clear_joys();
        core_mod[`BOARD_MOD_4WAY] = 1'b1;
        raw_v[0] = 16'h0001;              // right
        drive_joys();
        tick(4);
        raw_v[0] = 16'h0009;              // right and up
        drive_joys();
        tick(4);
        check_joy("4-way right then up", game_joystick1, ~board_pkg::game_joy_t'(10'h001));
        raw_v[0] = 16'h0008;
        drive_joys();
        tick(4);
        raw_v[0] = 16'h000a;              // up and left
        drive_joys();
        tick(4);
        check_joy("4-way up then left", game_joystick1, ~board_pkg::game_joy_t'(10'h008));
        core_mod[`BOARD_MOD_4WAY] = 1'b0;
        tick(4);
        check_joy("8-way diagonal", game_joystick1, ~board_pkg::game_joy_t'(10'h00a));
        clear_joys();
    endtask

    task automatic test_pause();
        int len;
        key_pause = 1'b1;
        tick(1);
        key_pause = 1'b0;
        tick(3);
        check_bit("dip_pause after key_pause", dip_pause, 1'b0);
        raw_v[1][`BOARD_PAUSE_BIT] = 1'b1;
        drive_joys();
        tick(4);
        check_bit("dip_pause after joy pause", dip_pause, 1'b1);
        clear_joys();
        tick(4);
        status[`BOARD_ST_PAUSE] = 1'b1;
        tick(4);
        status[`BOARD_ST_PAUSE] = 1'b0;
        tick(4);
        check_bit("dip_pause after osd pause", dip_pause, 1'b0);  // toggle must persist
        downloading = 1'b1;
        tick(4);
        check_bit("dip_pause while downloading", dip_pause, 1'b1);
        check_bit("game_rst while downloading", game_rst, 1'b1);
        downloading = 1'b0;
        rst_pulse_len(len);
        check_count("download reset stretch", len, RST_LEN + 1);
    endtask

    task automatic test_soft_rst_gfx_flip();
        int         len;
        logic [3:0] exp_gfx;
        key_reset = 1'b1;
        tick(1);
        key_reset = 1'b0;
        rst_pulse_len(len);
        check_count("soft reset stretch", len, RST_LEN + 1);
        status[`BOARD_ST_FLIP] = ~status[`BOARD_ST_FLIP];
        rst_pulse_len(len);
        check_count("flip reset stretch", len, RST_LEN + 1);
        exp_gfx = 4'hf;   // no gfx key pressed since reset
        for (int i = 0; i < 4; i++) begin
            key_gfx = 4'(1 << i);
            tick(1);
            key_gfx = '0;
            tick(3);
            exp_gfx[i] = ~exp_gfx[i];
            check_nib("gfx_en toggle", gfx_en, exp_gfx);
        end
    endtask

    initial begin
        clk_sys     = 1'b0;
        rst         = 1'b1;
        rst_req     = 1'b0;
        downloading = 1'b0;
        core_mod    = '0;
        status      = '0;
        key_start   = '0;
        key_coin    = '0;
        key_gfx     = '0;
        key_service = 1'b0;
        key_reset   = 1'b0;
        key_pause   = 1'b0;
        clear_joys();
        tick(5);
        test_reset();
        test_status_fields();
        test_joy_map(1'b0);
        test_joy_map(1'b1);
        test_coin_start();
        test_4way();
        test_pause();
        test_soft_rst_gfx_flip();
        $display("checks: %0d errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog timeout after %0d cycles, tests did not finish", WATCHDOG_CYCLES);
        $display("sim failed");
        $finish;
    end

endmodule

/* rtl/board_top.sv */
// arcade board input top level

`timescale 1ns/1ps

module board_top (
    input  logic                  clk_sys,
    input  logic                  rst,
    input  logic                  rst_req,
    input  logic                  downloading,
    input  logic [ 6:0]           core_mod,
    input  logic [31:0]           status,
    input  board_pkg::raw_joy_t   board_joystick1,
    input  board_pkg::raw_joy_t   board_joystick2,
    input  board_pkg::raw_joy_t   board_joystick3,
    input  board_pkg::raw_joy_t   board_joystick4,
    // decoded keyboard
    input  board_pkg::game_joy_t  key_joy1,
    input  board_pkg::game_joy_t  key_joy2,
    input  board_pkg::game_joy_t  key_joy3,
    input  logic [ 3:0]           key_start,
    input  logic [ 3:0]           key_coin,
    input  logic                  key_service,
    input  logic                  key_reset,
    input  logic                  key_pause,
    input  logic [ 3:0]           key_gfx,
    output logic                  game_rst,
    output logic                  game_rst_n,
    output board_pkg::game_joy_t  game_joystick1,
    output board_pkg::game_joy_t  game_joystick2,
    output board_pkg::game_joy_t  game_joystick3,
    output board_pkg::game_joy_t  game_joystick4,
    output logic [ 3:0]           game_coin,
    output logic [ 3:0]           game_start,
    output logic                  game_service,
    output logic                  dip_test,
    output logic                  dip_pause,
    output logic [ 1:0]           dip_fxlevel,
    output logic [ 3:0]           gfx_en
);

    logic joy_pause;
    logic soft_rst;

    board_cfg_if cfg ();

    dip_decode u_dip (
        .clk_sys, .rst, .status, .core_mod,
        .cfg         (cfg.dec),
        .dip_test, .dip_pause, .dip_fxlevel
    );

    input_mapper u_map (
        .clk_sys, .rst,
        .board_joystick1, .board_joystick2, .board_joystick3, .board_joystick4,
        .key_joy1, .key_joy2, .key_joy3, .key_start, .key_coin, .key_service,
        .cfg         (cfg.map),
        .game_joystick1, .game_joystick2, .game_joystick3, .game_joystick4,
        .game_coin, .game_start, .game_service,
        .joy_pause   (joy_pause)
    );

    board_control u_ctrl (
        .clk_sys, .rst, .key_reset, .key_pause,
        .joy_pause   (joy_pause),
        .downloading, .key_gfx,
        .cfg         (cfg.ctrl),
        .soft_rst    (soft_rst),
        .gfx_en
    );

    game_reset_gen u_rst (
        .clk_sys, .rst, .rst_req, .downloading,
        .soft_rst    (soft_rst),
        .cfg         (cfg.rst_src),
        .game_rst, .game_rst_n
    );

endmodule

/* rtl/game_reset_gen.sv */
// game reset stretcher

`timescale 1ns/1ps

`include "board_defs.svh"

module game_reset_gen (
    input  logic          clk_sys,
    input  logic          rst,
    input  logic          rst_req,
    input  logic          downloading,
    input  logic          soft_rst,
    board_cfg_if.rst_src  cfg,
    output logic          game_rst,
    output logic          game_rst_n
);

    localparam int CNT_W = $clog2(`BOARD_GAME_RST_LEN + 1);

    logic [CNT_W-1:0] rst_cnt;
    logic             last_flip;
    logic             pre_rst_n;
    logic             rst_src;

    always_ff @(posedge clk_sys) last_flip <= cfg.dip_flip; // flip history

    assign rst_src = rst | rst_req | downloading | soft_rst | (last_flip != cfg.dip_flip);

    // counter restarts while any source is high
    always_ff @(posedge clk_sys) begin
        if (rst_src) begin
            rst_cnt  <= '0;
            game_rst <= 1'b1;
        end else if (rst_cnt != CNT_W'(`BOARD_GAME_RST_LEN)) begin
            rst_cnt  <= rst_cnt + 1'b1;
            game_rst <= 1'b1;
        end else begin
            game_rst <= 1'b0;
        end
    end

    // two-stage release of the active-low copy
    always_ff @(posedge clk_sys) begin
        if (rst || game_rst) begin
            pre_rst_n  <= 1'b0;
            game_rst_n <= 1'b0;
        end else begin
            pre_rst_n  <= 1'b1;
            game_rst_n <= pre_rst_n;
        end
    end

endmodule

/* rtl/board_control.sv */
// pause, soft reset and gfx toggles

`timescale 1ns/1ps

module board_control (
    input  logic        clk_sys,
    input  logic        rst,
    input  logic        key_reset,
    input  logic        key_pause,
    input  logic        joy_pause,
    input  logic        downloading,
    input  logic [3:0]  key_gfx,
    board_cfg_if.ctrl   cfg,
    output logic        soft_rst,
    output logic [3:0]  gfx_en
);

    logic       last_reset;
    logic       last_key_pause;
    logic       last_joy_pause;
    logic       last_osd_pause;
    logic [3:0] last_gfx;
    logic       pause_edge;

    // any of the three pause sources toggles
    assign pause_edge = (key_pause && !last_key_pause) ||
                        (joy_pause && !last_joy_pause) ||
                        (cfg.osd_pause && !last_osd_pause);

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            last_reset     <= 1'b0;
            last_key_pause <= 1'b0;
            last_joy_pause <= 1'b0;
            last_osd_pause <= 1'b0;
            last_gfx       <= 4'h0;
            soft_rst       <= 1'b0;
            cfg.game_pause <= 1'b0;
            gfx_en         <= 4'hf;   // all layers on
        end else begin
            last_reset     <= key_reset;
            last_key_pause <= key_pause;
            last_joy_pause <= joy_pause;
            last_osd_pause <= cfg.osd_pause;
            last_gfx       <= key_gfx;
            soft_rst       <= key_reset && !last_reset;  // one cycle pulse
            if (downloading) begin
                cfg.game_pause <= 1'b0;
            end else if (pause_edge) begin
                cfg.game_pause <= ~cfg.game_pause;
            end
            for (int i = 0; i < 4; i++) begin
                if (key_gfx[i] && !last_gfx[i]) gfx_en[i] <= ~gfx_en[i];
            end
        end
    end

endmodule

/* rtl/input_mapper.sv */
// game input mapper

`timescale 1ns/1ps

`include "board_defs.svh"

module input_mapper (
    input  logic                  clk_sys,
    input  logic                  rst,
    input  board_pkg::raw_joy_t   board_joystick1,
    input  board_pkg::raw_joy_t   board_joystick2,
    input  board_pkg::raw_joy_t   board_joystick3,
    input  board_pkg::raw_joy_t   board_joystick4,
    input  board_pkg::game_joy_t  key_joy1,
    input  board_pkg::game_joy_t  key_joy2,
    input  board_pkg::game_joy_t  key_joy3,
    input  logic [3:0]            key_start,
    input  logic [3:0]            key_coin,
    input  logic                  key_service,
    board_cfg_if.map              cfg,
    output board_pkg::game_joy_t  game_joystick1,
    output board_pkg::game_joy_t  game_joystick2,
    output board_pkg::game_joy_t  game_joystick3,
    output board_pkg::game_joy_t  game_joystick4,
    output logic [3:0]            game_coin,
    output logic [3:0]            game_start,
    output logic                  game_service,
    output logic                  joy_pause
);

    board_pkg::raw_joy_t  raw      [4];
    board_pkg::raw_joy_t  joy_sync [4];
    board_pkg::game_joy_t key_joy  [4];
    board_pkg::game_joy_t game_joy [4];
    board_pkg::dir_t      joy4     [4];

    // swaps right/left and down/up
    function automatic board_pkg::game_joy_t rotate_joy(input board_pkg::game_joy_t j,
                                                         input logic rot);
        if (!rot) begin
            return j;
        end
        return {j[`BOARD_JOY_W-1:4], j[2], j[3], j[0], j[1]};
    endfunction

    assign raw     = '{board_joystick1, board_joystick2, board_joystick3, board_joystick4};
    assign key_joy = '{key_joy1, key_joy2, key_joy3, '0}; // no keys for player 4

    for (genvar p = 0; p < 4; p++) begin : g_filt
        joy_4way_filter u_filt (
            .clk_sys (clk_sys),
            .rst     (rst),
            .enable  (cfg.en4way),
            .joy8    (raw[p][`BOARD_DIR_W-1:0]),
            .joy4    (joy4[p])
        );
    end

    always_ff @(posedge clk_sys) begin
        for (int i = 0; i < 4; i++) begin
            joy_sync[i] <= {raw[i][`BOARD_RAW_JOY_W-1:`BOARD_DIR_W], joy4[i]};
        end
    end

    // merged with keys, rotated, then made active low
    always_ff @(posedge clk_sys) begin
        for (int i = 0; i < 4; i++) begin
            game_joy[i]   <= ~rotate_joy(joy_sync[i][`BOARD_JOY_W-1:0] | key_joy[i],
                                         cfg.rot_control);
            game_coin[i]  <= ~(joy_sync[i][`BOARD_COIN_BIT] | key_coin[i]);
            game_start[i] <= ~(joy_sync[i][`BOARD_START_BIT] | key_start[i]);
        end
        game_service <= ~key_service;
    end

    assign game_joystick1 = game_joy[0];
    assign game_joystick2 = game_joy[1];
    assign game_joystick3 = game_joy[2];
    assign game_joystick4 = game_joy[3];

    assign joy_pause = joy_sync[0][`BOARD_PAUSE_BIT] | joy_sync[1][`BOARD_PAUSE_BIT];

endmodule

/* rtl/joy_4way_filter.sv */
// 4-way joystick filter

`timescale 1ns/1ps

module joy_4way_filter (
    input  logic              clk_sys,
    input  logic              rst,
    input  logic              enable,
    input  board_pkg::dir_t   joy8,
    output board_pkg::dir_t   joy4
);

    board_pkg::joy_axis_e last_axis;
    logic horiz;
    logic vert;

    assign horiz = |joy8[1:0];  // right or left
    assign vert  = |joy8[3:2];  // down or up

    // remember the axis of the last single-axis press
    always_ff @(posedge clk_sys) begin
        if (rst) begin
            last_axis <= board_pkg::axis_none;
        end else if (horiz && !vert) begin
            last_axis <= board_pkg::axis_horiz;
        end else if (vert && !horiz) begin
            last_axis <= board_pkg::axis_vert;
        end
    end

    // on a diagonal keep only the remembered axis
    always_comb begin
        joy4 = joy8;
        if (enable && horiz && vert) begin
            if (last_axis == board_pkg::axis_horiz) begin
                joy4 = {2'b00, joy8[1:0]};
            end else begin
                joy4 = {joy8[3:2], 2'b00}; // vertical wins by default
            end
        end
    end

endmodule

/* rtl/dip_decode.sv */
// status word decoder

`timescale 1ns/1ps

`include "board_defs.svh"

module dip_decode (
    input  logic        clk_sys,
    input  logic        rst,
    input  logic [31:0] status,
    input  logic [ 6:0] core_mod,
    board_cfg_if.dec    cfg,
    output logic        dip_test,
    output logic        dip_pause,
    output logic [ 1:0] dip_fxlevel
);

    // plain mirrors of the status fields
    always_ff @(posedge clk_sys) begin
        cfg.rot_control <= status[`BOARD_ST_ROT];
        cfg.dip_flip    <= status[`BOARD_ST_FLIP];
        cfg.en4way      <= core_mod[`BOARD_MOD_4WAY];
        dip_test        <= ~status[`BOARD_ST_TEST];   // active low
        dip_fxlevel     <= status[`BOARD_ST_FX_LO +: 2];
    end

    // pause state feeds the control edge detector
    always_ff @(posedge clk_sys) begin
        if (rst) begin
            cfg.osd_pause <= 1'b0;
            dip_pause     <= 1'b1;    // running
        end else begin
            cfg.osd_pause <= status[`BOARD_ST_PAUSE];
            dip_pause     <= ~(cfg.game_pause | status[`BOARD_ST_PAUSE]);
        end
    end

endmodule

/* rtl/board_cfg_if.sv */
// decoded board settings

`timescale 1ns/1ps

interface board_cfg_if;

    logic rot_control;  // swap control axes
    logic osd_pause;    // pause request from the OSD
    logic dip_flip;
    logic en4way;       // 4-way joystick filter on
    logic game_pause;

    // settings decoder
    modport dec (output rot_control, osd_pause, dip_flip, en4way, input game_pause);

    // pause and gfx toggles
    modport ctrl (output game_pause, input osd_pause);

    modport map (input rot_control, en4way);

    // flip change triggers a game reset
    modport rst_src (input dip_flip);

endinterface

/* rtl/board_pkg.sv */
// board input types

`include "board_defs.svh"

package board_pkg;

    // joystick as delivered by the board
    typedef logic [`BOARD_RAW_JOY_W-1:0] raw_joy_t;

    // joystick as seen by the game core
    typedef logic [`BOARD_JOY_W-1:0] game_joy_t;

    // one group of direction bits
    typedef logic [`BOARD_DIR_W-1:0] dir_t;

    // last axis pressed on its own, used by the 4-way filter
    typedef enum logic [1:0] {
        axis_none,
        axis_horiz,
        axis_vert
    } joy_axis_e;

endpackage

/* include/board_defs.svh */
// board wrapper constants
`ifndef BOARD_DEFS_SVH
`define BOARD_DEFS_SVH

// game input layout
`define BOARD_BUTTONS       2
`define BOARD_RAW_JOY_W     16
`define BOARD_JOY_W         10
`define BOARD_DIR_W         4     // 0 right, 1 left, 2 down, 3 up

// extra buttons push the system bits up
`define BOARD_START_BIT     (6 + `BOARD_BUTTONS - 2)
`define BOARD_COIN_BIT      (7 + `BOARD_BUTTONS - 2)
`define BOARD_PAUSE_BIT     (8 + `BOARD_BUTTONS - 2)

// cycles game_rst is held after its sources drop
`define BOARD_GAME_RST_LEN  16

// status word fields
`define BOARD_ST_ROT        2
`define BOARD_ST_FLIP       3
`define BOARD_ST_TEST       4
`define BOARD_ST_PAUSE      7
`define BOARD_ST_FX_LO      8     // two bits wide

// core_mod bits
`define BOARD_MOD_4WAY      1

`endif
